// File: include/core_params.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// datapath and address width
`define XLEN 32

// general register file
`define REG_COUNT 32
`define REG_IDX_W 5

// data memory depth in words, indexed by addr[9:2]
`define DMEM_WORDS 256

// first fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

// File: hw/isa_pkg.sv
`default_nettype none

package isa_pkg;

  typedef enum logic [6:0] {
    opc_load   = 7'b0000011,
    opc_op_imm = 7'b0010011,
    opc_store  = 7'b0100011,
    opc_op     = 7'b0110011,
    opc_lui    = 7'b0110111,
    opc_branch = 7'b1100011
  } opcode_e;

  // shared by op and op_imm
  typedef enum logic [2:0] {
    f3_add_sub = 3'b000,
    f3_sll     = 3'b001,
    f3_xor     = 3'b100,
    f3_srl_sra = 3'b101,
    f3_or      = 3'b110,
    f3_and     = 3'b111
  } alu_funct3_e;

  typedef enum logic [2:0] {
    f3_beq  = 3'b000,
    f3_bne  = 3'b001,
    f3_blt  = 3'b100,
    f3_bge  = 3'b101,
    f3_bltu = 3'b110,
    f3_bgeu = 3'b111
  } branch_funct3_e;

  localparam logic [2:0] funct3_word = 3'b010; // lw / sw width
  localparam logic [6:0] funct7_alt  = 7'b0100000; // sub, sra, srai

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_e    opcode;
  } r_fmt_s;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_e     opcode;
  } i_fmt_s;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    opcode_e    opcode;
  } s_fmt_s;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    opcode_e    opcode;
  } b_fmt_s;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    opcode_e     opcode;
  } u_fmt_s;

  // one instruction word, five views
  typedef union packed {
    r_fmt_s r;
    i_fmt_s i;
    s_fmt_s s;
    b_fmt_s b;
    u_fmt_s u;
  } instr_u;

endpackage

`default_nettype wire

// File: hw/core_pkg.sv
`default_nettype none

`include "core_params.svh"

package core_pkg;

  typedef enum logic [3:0] {
    alu_add      = 4'd0,
    alu_sub      = 4'd1,
    alu_sll      = 4'd2,
    alu_srl      = 4'd3,
    alu_sra      = 4'd4,
    alu_and      = 4'd5,
    alu_or       = 4'd6,
    alu_xor      = 4'd7,
    alu_pass_imm = 4'd8 // lui
  } alu_op_e;

  typedef enum logic [2:0] {
    br_none = 3'd0,
    br_eq   = 3'd1,
    br_ne   = 3'd2,
    br_lt   = 3'd3,
    br_ge   = 3'd4,
    br_ltu  = 3'd5,
    br_geu  = 3'd6
  } branch_e;

  typedef struct packed {
    alu_op_e alu_op;
    branch_e branch;
    logic    use_imm;   // imm replaces rs2 as operand b
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
  } ctrl_s;

  // what an unknown word decodes to
  localparam ctrl_s ctrl_nop = '{
    alu_op:    alu_add,
    branch:    br_none,
    use_imm:   1'b0,
    reg_write: 1'b0,
    mem_read:  1'b0,
    mem_write: 1'b0
  };

  typedef struct packed {
    logic                  valid;
    logic [`XLEN-1:0]      pc;
    logic                  reg_write;
    logic [`REG_IDX_W-1:0] rd;
    logic [`XLEN-1:0]      wb_data;
  } retire_s;

endpackage

`default_nettype wire

// File: hw/instr_decode.sv
`default_nettype none

`include "core_params.svh"

module instr_decode (
  input  logic [`XLEN-1:0]      instr,
  output logic [`REG_IDX_W-1:0] rs1,
  output logic [`REG_IDX_W-1:0] rs2,
  output logic [`REG_IDX_W-1:0] rd,
  output logic [`XLEN-1:0]      imm,
  output core_pkg::ctrl_s       ctrl
);

  isa_pkg::instr_u iw;
  logic            alt_funct7;
  logic            is_imm_op;

  assign iw = instr;

  // register fields sit at the same place in every format
  assign rs1 = iw.r.rs1;
  assign rs2 = iw.r.rs2;
  assign rd  = iw.r.rd;

  assign alt_funct7 = (iw.r.funct7 == isa_pkg::funct7_alt);
  assign is_imm_op  = (iw.r.opcode == isa_pkg::opc_op_imm);

  always_comb begin
    case (iw.r.opcode)
      isa_pkg::opc_op_imm,
      isa_pkg::opc_load:   imm = {{(`XLEN-12){iw.i.imm[11]}}, iw.i.imm};
      isa_pkg::opc_store:  imm = {{(`XLEN-12){iw.s.imm_11_5[6]}}, iw.s.imm_11_5, iw.s.imm_4_0};
      isa_pkg::opc_branch: imm = {{(`XLEN-13){iw.b.imm_12}}, iw.b.imm_12, iw.b.imm_11,
                                  iw.b.imm_10_5, iw.b.imm_4_1, 1'b0};
      isa_pkg::opc_lui:    imm = {iw.u.imm, 12'b0};
      default:             imm = '0;
    endcase
  end

  always_comb begin
    ctrl = core_pkg::ctrl_nop;
    case (iw.r.opcode)
      isa_pkg::opc_op,
      isa_pkg::opc_op_imm: begin
        ctrl.reg_write = 1'b1;
        ctrl.use_imm   = is_imm_op;
        case (iw.r.funct3)
          isa_pkg::f3_add_sub: begin
            // addi has no sub form, upper imm bits are just immediate
            ctrl.alu_op = (alt_funct7 && !is_imm_op) ? core_pkg::alu_sub : core_pkg::alu_add;
          end
          isa_pkg::f3_sll:     ctrl.alu_op = core_pkg::alu_sll;
          isa_pkg::f3_srl_sra: ctrl.alu_op = alt_funct7 ? core_pkg::alu_sra : core_pkg::alu_srl;
          isa_pkg::f3_xor:     ctrl.alu_op = core_pkg::alu_xor;
          isa_pkg::f3_or:      ctrl.alu_op = core_pkg::alu_or;
          isa_pkg::f3_and:     ctrl.alu_op = core_pkg::alu_and;
          default:             ctrl = core_pkg::ctrl_nop; // slt family not supported
        endcase
      end
      isa_pkg::opc_load: begin
        if (iw.i.funct3 == isa_pkg::funct3_word) begin
          ctrl.use_imm   = 1'b1;
          ctrl.reg_write = 1'b1;
          ctrl.mem_read  = 1'b1;
        end
      end
      isa_pkg::opc_store: begin
        if (iw.s.funct3 == isa_pkg::funct3_word) begin
          ctrl.use_imm   = 1'b1;
          ctrl.mem_write = 1'b1;
        end
      end
      isa_pkg::opc_branch: begin
        case (iw.b.funct3)
          isa_pkg::f3_beq:  ctrl.branch = core_pkg::br_eq;
          isa_pkg::f3_bne:  ctrl.branch = core_pkg::br_ne;
          isa_pkg::f3_blt:  ctrl.branch = core_pkg::br_lt;
          isa_pkg::f3_bge:  ctrl.branch = core_pkg::br_ge;
          isa_pkg::f3_bltu: ctrl.branch = core_pkg::br_ltu;
          isa_pkg::f3_bgeu: ctrl.branch = core_pkg::br_geu;
          default:          ctrl.branch = core_pkg::br_none;
        endcase
      end
      isa_pkg::opc_lui: begin
        ctrl.alu_op    = core_pkg::alu_pass_imm;
        ctrl.use_imm   = 1'b1;
        ctrl.reg_write = 1'b1;
      end
      default: ctrl = core_pkg::ctrl_nop;
    endcase
  end

endmodule

`default_nettype wire

// File: hw/reg_file.sv
`default_nettype none

`include "core_params.svh"

module reg_file (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  write_en,
  input  logic [`REG_IDX_W-1:0] rs1,
  input  logic [`REG_IDX_W-1:0] rs2,
  input  logic [`REG_IDX_W-1:0] rd,
  input  logic [`XLEN-1:0]      wb_data,
  output logic [`XLEN-1:0]      rs1_data,
  output logic [`XLEN-1:0]      rs2_data
);

  logic [`REG_COUNT-1:0][`XLEN-1:0] regs;

  // async read ports
  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      regs <= '0;
    end else if (write_en && (rd != '0)) begin // x0 never written
      regs[rd] <= wb_data;
    end
  end

endmodule

`default_nettype wire

// File: hw/alu_unit.sv
`default_nettype none

`include "core_params.svh"

module alu_unit (
  input  core_pkg::ctrl_s  ctrl,
  input  logic [`XLEN-1:0] rs1_data,
  input  logic [`XLEN-1:0] rs2_data,
  input  logic [`XLEN-1:0] imm,
  output logic [`XLEN-1:0] alu_result,
  output logic             branch_taken
);

  localparam int shamt_w = $clog2(`XLEN);

  logic [`XLEN-1:0]   op_b;
  logic [shamt_w-1:0] shamt;

  assign op_b  = ctrl.use_imm ? imm : rs2_data;
  assign shamt = op_b[shamt_w-1:0];

  always_comb begin
    case (ctrl.alu_op)
      core_pkg::alu_add:      alu_result = rs1_data + op_b;
      core_pkg::alu_sub:      alu_result = rs1_data - op_b;
      core_pkg::alu_sll:      alu_result = rs1_data << shamt;
      core_pkg::alu_srl:      alu_result = rs1_data >> shamt;
      core_pkg::alu_sra:      alu_result = $signed(rs1_data) >>> shamt;
      core_pkg::alu_and:      alu_result = rs1_data & op_b;
      core_pkg::alu_or:       alu_result = rs1_data | op_b;
      core_pkg::alu_xor:      alu_result = rs1_data ^ op_b;
      core_pkg::alu_pass_imm: alu_result = imm;
      default:                alu_result = '0;
    endcase
  end

  // compare register values directly, not via subtract flags
  always_comb begin
    case (ctrl.branch)
      core_pkg::br_eq:  branch_taken = (rs1_data == rs2_data);
      core_pkg::br_ne:  branch_taken = (rs1_data != rs2_data);
      core_pkg::br_lt:  branch_taken = ($signed(rs1_data) < $signed(rs2_data));
      core_pkg::br_ge:  branch_taken = ($signed(rs1_data) >= $signed(rs2_data));
      core_pkg::br_ltu: branch_taken = (rs1_data < rs2_data);
      core_pkg::br_geu: branch_taken = (rs1_data >= rs2_data);
      default:          branch_taken = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// File: hw/fetch_pc.sv
`default_nettype none

`include "core_params.svh"

module fetch_pc (
  input  logic             clk,
  input  logic             rst,
  input  logic             step,
  input  logic             branch_taken,
  input  logic [`XLEN-1:0] imm,
  output logic [`XLEN-1:0] pc
);

  localparam logic [`XLEN-1:0] instr_bytes = 4;

  logic [`XLEN-1:0] next_pc;

  assign next_pc = branch_taken ? (pc + imm) : (pc + instr_bytes);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc <= `RESET_PC;
    end else if (step) begin // hold while idle
      pc <= next_pc;
    end
  end

endmodule

`default_nettype wire

// File: hw/mem_stage.sv
`default_nettype none

`include "core_params.svh"

module mem_stage (
  input  logic             clk,
  input  logic             step,
  input  core_pkg::ctrl_s  ctrl,
  input  logic [`XLEN-1:0] addr,
  input  logic [`XLEN-1:0] store_data,
  output logic [`XLEN-1:0] wb_data
);

  localparam int idx_w = $clog2(`DMEM_WORDS);

  logic [`XLEN-1:0] dmem [`DMEM_WORDS];
  logic [idx_w-1:0] word_idx;
  logic [`XLEN-1:0] load_data;

  // word addressed, low two bits dropped
  assign word_idx  = addr[idx_w+1:2];
  assign load_data = dmem[word_idx];

  always_ff @(posedge clk) begin
    if (step && ctrl.mem_write) begin
      dmem[word_idx] <= store_data;
    end
  end

  assign wb_data = ctrl.mem_read ? load_data : addr; // addr is the alu result

endmodule

`default_nettype wire

// File: hw/rv_core.sv
`default_nettype none

`include "core_params.svh"

module rv_core (
  input  logic              clk,
  input  logic              rst,
  input  logic              step,
  output logic [`XLEN-1:0]  instr_addr,
  input  logic [`XLEN-1:0]  instr,
  output core_pkg::retire_s retire
);

  core_pkg::ctrl_s       ctrl;
  logic [`REG_IDX_W-1:0] rs1;
  logic [`REG_IDX_W-1:0] rs2;
  logic [`REG_IDX_W-1:0] rd;
  logic [`XLEN-1:0]      imm;
  logic [`XLEN-1:0]      rs1_data;
  logic [`XLEN-1:0]      rs2_data;
  logic [`XLEN-1:0]      alu_result;
  logic                  branch_taken;
  logic [`XLEN-1:0]      wb_data;
  logic [`XLEN-1:0]      pc;
  logic                  reg_write_en;

  assign instr_addr   = pc;
  assign reg_write_en = ctrl.reg_write & step;

  instr_decode decode_i (
    .instr (instr),
    .rs1   (rs1),
    .rs2   (rs2),
    .rd    (rd),
    .imm   (imm),
    .ctrl  (ctrl)
  );

  reg_file regs_i (
    .clk      (clk),
    .rst      (rst),
    .write_en (reg_write_en),
    .rs1      (rs1),
    .rs2      (rs2),
    .rd       (rd),
    .wb_data  (wb_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  alu_unit alu_i (
    .ctrl         (ctrl),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .imm          (imm),
    .alu_result   (alu_result),
    .branch_taken (branch_taken)
  );

  fetch_pc fetch_i (
    .clk          (clk),
    .rst          (rst),
    .step         (step),
    .branch_taken (branch_taken),
    .imm          (imm),
    .pc           (pc)
  );

  mem_stage mem_i (
    .clk        (clk),
    .step       (step),
    .ctrl       (ctrl),
    .addr       (alu_result),
    .store_data (rs2_data),
    .wb_data    (wb_data)
  );

  // this cycle's instruction, commits on the next edge
  assign retire.valid     = step;
  assign retire.pc        = pc;
  assign retire.reg_write = ctrl.reg_write;
  assign retire.rd        = rd;
  assign retire.wb_data   = wb_data;

endmodule

`default_nettype wire

// File: tests/tb_clock.sv
`default_nettype none

module tb_clock (
  output logic clk,
  output logic rst
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk; // 40 ns period
  end

  initial begin
    rst = 1'b1;
    repeat (5) @(posedge clk);
    #2 rst = 1'b0;
  end

endmodule

`default_nettype wire

// File: tests/retire_checker.sv
`default_nettype none

`include "core_params.svh"

module retire_checker (
  input  logic              clk,
  input  logic              rst,
  input  logic              step,
  input  logic [`XLEN-1:0]  instr_addr,
  input  core_pkg::retire_s retire,
  input  core_pkg::retire_s expected,
  input  logic [`XLEN-1:0]  exp_next,
  output int                checks,
  output int                errors
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [`XLEN-1:0] exp_addr = `RESET_PC; // where the pc should sit now

  task automatic check_value(input string name, input logic [`XLEN-1:0] exp,
                             input logic [`XLEN-1:0] got);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED t=%0t %s expected=%h got=%h", $time, name, exp, got);
    end
  endtask

  initial begin
    checks = 0;
    errors = 0;
  end

  // sampled at the edge, before the core updates
  always @(posedge clk) begin
    if (!rst) begin
      check_value("instr_addr", exp_addr, instr_addr);
      check_value("retire.valid", expected.valid, retire.valid);
      if (step) begin
        check_value("retire.pc", expected.pc, retire.pc);
        check_value("retire.reg_write", expected.reg_write, retire.reg_write);
        if (expected.reg_write) begin // rd field means nothing for stores and branches
          check_value("retire.rd", expected.rd, retire.rd);
          check_value("retire.wb_data", expected.wb_data, retire.wb_data);
        end
        exp_addr <= exp_next;
      end
    end
  end

endmodule

`default_nettype wire

// File: tests/rv_core_tb.sv
`default_nettype none

`include "core_params.svh"

module rv_core_tb;
  timeunit 1ns;
  timeprecision 1ps;

  typedef struct packed {
    logic [`XLEN-1:0]      addr;
    logic [`XLEN-1:0]      word;
    logic                  reg_write;
    logic [`REG_IDX_W-1:0] rd;
    logic [`XLEN-1:0]      wb_data;
    logic [`XLEN-1:0]      next_addr;
  } row_s;

  localparam int rows = 32;
  localparam int cycle_limit = 5 + rows * 4 + 20;

  // x1 = 5 and x2 = -3 from the first two rows on
  row_s prog [rows] = '{
    '{'h00, 32'h00500093, 1, 1,  32'h0000_0005, 'h04}, // addi x1, x0, 5
    '{'h04, 32'hFFD00113, 1, 2,  32'hFFFF_FFFD, 'h08}, // addi x2, x0, -3
    '{'h08, 32'h002081B3, 1, 3,  32'h0000_0002, 'h0c}, // add x3, x1, x2
    '{'h0c, 32'h40220233, 1, 4,  32'h0000_0003, 'h10}, // sub x4, x4, x2 with x4 still 0
    '{'h10, 32'h401152B3, 1, 5,  32'hFFFF_FFFF, 'h14}, // sra x5, x2, x1
    '{'h14, 32'h00115333, 1, 6,  32'h07FF_FFFF, 'h18}, // srl x6, x2, x1
    '{'h18, 32'h001093B3, 1, 7,  32'h0000_00A0, 'h1c}, // sll x7, x1, x1
    '{'h1c, 32'h0020C433, 1, 8,  32'hFFFF_FFF8, 'h20}, // xor x8, x1, x2
    '{'h20, 32'h0020E4B3, 1, 9,  32'hFFFF_FFFD, 'h24}, // or x9, x1, x2
    '{'h24, 32'h0020F533, 1, 10, 32'h0000_0005, 'h28}, // and x10, x1, x2
    '{'h28, 32'h00409593, 1, 11, 32'h0000_0050, 'h2c}, // slli x11, x1, 4
    '{'h2c, 32'h01C15613, 1, 12, 32'h0000_000F, 'h30}, // srli x12, x2, 28
    '{'h30, 32'h40115693, 1, 13, 32'hFFFF_FFFE, 'h34}, // srai x13, x2, 1
    '{'h34, 32'h0F017713, 1, 14, 32'h0000_00F0, 'h38}, // andi x14, x2, 0xf0
    '{'h38, 32'h1000E793, 1, 15, 32'h0000_0105, 'h3c}, // ori x15, x1, 0x100
    '{'h3c, 32'hFFF0C813, 1, 16, 32'hFFFF_FFFA, 'h40}, // xori x16, x1, -1
    '{'h40, 32'h00708013, 1, 0,  32'h0000_000C, 'h44}, // addi x0, x1, 7
    '{'h44, 32'h12345937, 1, 18, 32'h1234_5000, 'h48}, // lui x18, 0x12345
    '{'h48, 32'h0120A1A3, 0, 0,  32'h0000_0000, 'h4c}, // sw x18, 3(x1)
    '{'h4c, 32'h00802983, 1, 19, 32'h1234_5000, 'h50}, // lw x19, 8(x0), base must be 0
    '{'h50, 32'h00A08463, 0, 0,  32'h0000_0000, 'h58}, // beq x1, x10 taken
    '{'h58, 32'h00A09463, 0, 0,  32'h0000_0000, 'h5c}, // bne x1, x10 not taken
    '{'h5c, 32'h00114463, 0, 0,  32'h0000_0000, 'h64}, // blt x2, x1 taken
    '{'h64, 32'h00115463, 0, 0,  32'h0000_0000, 'h68}, // bge x2, x1 not taken
    '{'h68, 32'h00116463, 0, 0,  32'h0000_0000, 'h6c}, // bltu x2, x1 not taken
    '{'h6c, 32'h00117463, 0, 0,  32'h0000_0000, 'h74}, // bgeu x2, x1 taken
    '{'h74, 32'h0020D463, 0, 0,  32'h0000_0000, 'h7c}, // bge x1, x2 taken
    '{'h7c, 32'hFC20ECE3, 0, 0,  32'h0000_0000, 'h54}, // bltu x1, x2 taken, back by 40
    '{'h54, 32'h02209663, 0, 0,  32'h0000_0000, 'h80}, // bne x1, x2 taken, ahead 44
    '{'h80, 32'h0020C463, 0, 0,  32'h0000_0000, 'h84}, // blt x1, x2 not taken
    '{'h84, 32'h0020F463, 0, 0,  32'h0000_0000, 'h88}, // bgeu x1, x2 not taken
    '{'h88, 32'h00208463, 0, 0,  32'h0000_0000, 'h8c}  // beq x1, x2 not taken
  };

  logic              clk;
  logic              rst;
  logic              step;
  logic [`XLEN-1:0]  instr_addr;
  logic [`XLEN-1:0]  instr;
  core_pkg::retire_s retire;
  core_pkg::retire_s expected;
  logic [`XLEN-1:0]  exp_next;
  int                checks;
  int                errors;
  int                cycles = 0;
  logic [15:0]       lfsr = 16'd53663;

  tb_clock clock_i (.clk(clk), .rst(rst));

  rv_core rv_core_i (
    .clk        (clk),
    .rst        (rst),
    .step       (step),
    .instr_addr (instr_addr),
    .instr      (instr),
    .retire     (retire)
  );

  retire_checker checker_i (
    .clk        (clk),
    .rst        (rst),
    .step       (step),
    .instr_addr (instr_addr),
    .retire     (retire),
    .expected   (expected),
    .exp_next   (exp_next),
    .checks     (checks),
    .errors     (errors)
  );

  // instruction memory, same-cycle lookup
  always_comb begin
    instr = 32'h0000_0013; // nop off the table
    for (int i = 0; i < rows; i++) begin
      if (prog[i].addr == instr_addr) instr = prog[i].word;
    end
  end

  // x^16 + x^14 + x^13 + x^11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  initial begin
    int idle;
    step = 1'b0;
    expected = '0;
    exp_next = `RESET_PC;
    @(negedge rst);
    next_cycle();
    next_cycle();
    for (int r = 0; r < rows; r++) begin
      step = 1'b1;
      expected = '{valid: 1'b1, pc: prog[r].addr, reg_write: prog[r].reg_write,
                   rd: prog[r].rd, wb_data: prog[r].wb_data};
      exp_next = prog[r].next_addr;
      next_cycle();
      step = 1'b0;
      expected.valid = 1'b0;
      idle = 0;
      repeat (2) begin
        lfsr = lfsr_step(lfsr);
        idle = (idle << 1) | lfsr[0];
      end
      repeat (idle) next_cycle();
    end
    next_cycle();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0 && checks > 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: program did not finish within %0d cycles", cycle_limit);
      $display("FAIL: see errors above");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: project.f
+incdir+include
hw/isa_pkg.sv
hw/core_pkg.sv
hw/instr_decode.sv
hw/reg_file.sv
hw/alu_unit.sv
hw/fetch_pc.sv
hw/mem_stage.sv
hw/rv_core.sv
tests/tb_clock.sv
tests/retire_checker.sv
tests/rv_core_tb.sv

// File: Bender.yml
package:
  name: rv_core

export_include_dirs:
  - include

sources:
  - hw/isa_pkg.sv
  - hw/core_pkg.sv
  - hw/instr_decode.sv
  - hw/reg_file.sv
  - hw/alu_unit.sv
  - hw/fetch_pc.sv
  - hw/mem_stage.sv
  - hw/rv_core.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/retire_checker.sv
      - tests/rv_core_tb.sv
